/* hw/lane_pkg.sv */
// shared sizes for the multi-lane word buffer, imported by every rtl module and the testbench
`default_nettype none

package lane_pkg;

    // lane count and lane tag width
    localparam int num_lanes = 4;
    localparam int lane_w = 2;

    // per-lane fifo geometry
    localparam int lane_aw = 3;
    localparam int lane_depth = 8;

    // payload word
    localparam int data_w = 16;

    // output credit counter, up to 16 outstanding sink credits
    localparam int credit_w = 5;

endpackage

`default_nettype wire

/* hw/lane_ram.sv */
// per-lane dual-port storage with synchronous write and enabled registered read, used by lane_fifo
`timescale 1ns/1ps
`default_nettype none

module lane_ram import lane_pkg::*; (
    input  wire logic               clk,
    input  wire logic               wr_en,
    input  wire logic [lane_aw-1:0] wr_addr,
    input  wire logic [data_w-1:0]  wr_data,
    input  wire logic               rd_en,
    input  wire logic [lane_aw-1:0] rd_addr,
    output logic      [data_w-1:0]  rd_data
);

    // storage array, no reset
    logic [data_w-1:0] mem [0:lane_depth-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register holds its value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

/* hw/lane_fifo.sv */
// synchronous fifo for one lane, wrap-bit pointers around lane_ram; instantiated per lane in the top
`timescale 1ns/1ps
`default_nettype none

module lane_fifo import lane_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              wr_en,
    input  wire logic [data_w-1:0] wr_data,
    input  wire logic              rd_en,
    output logic      [data_w-1:0] rd_data,
    output logic                   full,
    output logic                   empty
);

    // pointers carry one extra wrap bit
    logic [lane_aw:0] wr_ptr;
    logic [lane_aw:0] rd_ptr;

    // same address on different laps
    assign full = (wr_ptr[lane_aw-1:0] == rd_ptr[lane_aw-1:0]) &&
                  (wr_ptr[lane_aw] != rd_ptr[lane_aw]);

    // same address, same lap
    assign empty = (wr_ptr == rd_ptr);

    // write pointer
    // enable already qualified by the dispatcher
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // read pointer
    // enable already qualified by the drain
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage, one clock on both ports
    lane_ram u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_ptr[lane_aw-1:0]),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_ptr[lane_aw-1:0]),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* hw/lane_dispatch.sv */
// input stage of the lane buffer, steers tagged words to their lane fifo and records overflow
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch import lane_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 in_valid,
    input  wire logic [lane_w-1:0]    in_lane,
    input  wire logic [data_w-1:0]    in_data,
    input  wire logic [num_lanes-1:0] lane_full,
    output logic      [num_lanes-1:0] lane_wr_en,
    output logic      [data_w-1:0]    lane_wr_data,
    output logic      [num_lanes-1:0] overflow
);

    // one-hot lane of the incoming word
    logic [num_lanes-1:0] lane_sel;

    // lanes hit while full
    logic [num_lanes-1:0] lane_drop;

    // tag decode
    always_comb begin
        lane_sel = '0;
        if (in_valid) begin
            lane_sel[in_lane] = 1'b1;
        end
    end

    // only place the full flag is looked at
    assign lane_wr_en = lane_sel & ~lane_full;
    assign lane_drop = lane_sel & lane_full;

    // data bus is shared, the enable picks the lane
    assign lane_wr_data = in_data;

    // sticky overflow per lane
    // dropped word is simply not written
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            overflow <= '0;
        end else begin
            overflow <= overflow | lane_drop;
        end
    end

endmodule

`default_nettype wire

/* hw/lane_drain.sv */
// output stage of the lane buffer: round-robin reads under sink credits, output regs, credit return
`timescale 1ns/1ps
`default_nettype none

module lane_drain import lane_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic [num_lanes-1:0]        lane_empty,
    input  wire logic [num_lanes*data_w-1:0] lane_rd_data,
    input  wire logic                        out_credit,
    output logic      [num_lanes-1:0]        lane_rd_en,
    output logic      [num_lanes-1:0]        in_credit,
    output logic                             out_valid,
    output logic      [lane_w-1:0]           out_lane,
    output logic      [data_w-1:0]           out_data
);

    // round-robin start point
    logic [lane_w-1:0] rr_ptr;

    // sink credits held
    logic [credit_w-1:0] credit_cnt;

    // arbiter results
    logic              found;
    logic [lane_w-1:0] grant_lane;
    logic [lane_w-1:0] idx;
    logic              rd_go;

    // stage between the ram read edge and the output edge
    logic              s1_valid;
    logic [lane_w-1:0] s1_lane;

    // first non-empty lane at or after rr_ptr
    always_comb begin
        found = 1'b0;
        grant_lane = rr_ptr;
        idx = rr_ptr;
        for (int i = 0; i < num_lanes; i++) begin
            // wraps naturally, lane count is a power of two
            idx = rr_ptr + lane_w'(i);
            if (!found && !lane_empty[idx]) begin
                found = 1'b1;
                grant_lane = idx;
            end
        end
    end

    // read only with a credit in hand
    assign rd_go = found && (credit_cnt != '0);

    // one-hot read enable
    always_comb begin
        lane_rd_en = '0;
        if (rd_go) begin
            lane_rd_en[grant_lane] = 1'b1;
        end
    end

    // freed entry goes straight back to the source
    assign in_credit = lane_rd_en;

    // pointer moves past the granted lane
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr_ptr <= '0;
        end else if (rd_go) begin
            rr_ptr <= grant_lane + 1'b1;
        end
    end

    // grants in, reads out, same cycle nets out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credit_cnt <= '0;
        end else begin
            credit_cnt <= credit_cnt + credit_w'(out_credit) - credit_w'(rd_go);
        end
    end

    // valid bits of the two stages
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid <= rd_go;
            out_valid <= s1_valid;
        end
    end

    // lane tag follows the ram read
    always_ff @(posedge clk) begin
        s1_lane <= grant_lane;
    end

    // pick that lane's registered read data
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_lane <= s1_lane;
            out_data <= lane_rd_data[s1_lane*data_w +: data_w];
        end
    end

endmodule

`default_nettype wire

/* hw/lane_buffer_top.sv */
// top of the multi-lane word buffer; dispatcher, per-lane fifos and drain, the unit under test
`timescale 1ns/1ps
`default_nettype none

module lane_buffer_top import lane_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 in_valid,
    input  wire logic [lane_w-1:0]    in_lane,
    input  wire logic [data_w-1:0]    in_data,
    input  wire logic                 out_credit,
    output logic      [num_lanes-1:0] in_credit,
    output logic                      out_valid,
    output logic      [lane_w-1:0]    out_lane,
    output logic      [data_w-1:0]    out_data,
    output logic      [num_lanes-1:0] overflow
);

    // dispatcher side
    logic [num_lanes-1:0] lane_wr_en;
    logic [data_w-1:0]    lane_wr_data;
    logic [num_lanes-1:0] lane_full;

    // drain side
    logic [num_lanes-1:0]        lane_rd_en;
    logic [num_lanes-1:0]        lane_empty;
    logic [num_lanes*data_w-1:0] lane_rd_data;

    // tag decode and overflow
    lane_dispatch u_dispatch (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .in_lane      (in_lane),
        .in_data      (in_data),
        .lane_full    (lane_full),
        .lane_wr_en   (lane_wr_en),
        .lane_wr_data (lane_wr_data),
        .overflow     (overflow)
    );

    // one fifo per lane
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        lane_fifo u_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .wr_en   (lane_wr_en[g]),
            .wr_data (lane_wr_data),
            .rd_en   (lane_rd_en[g]),
            .rd_data (lane_rd_data[g*data_w +: data_w]),
            .full    (lane_full[g]),
            .empty   (lane_empty[g])
        );
    end

    // arbitration, output credits, credit return
    lane_drain u_drain (
        .clk          (clk),
        .rstn         (rstn),
        .lane_empty   (lane_empty),
        .lane_rd_data (lane_rd_data),
        .out_credit   (out_credit),
        .lane_rd_en   (lane_rd_en),
        .in_credit    (in_credit),
        .out_valid    (out_valid),
        .out_lane     (out_lane),
        .out_data     (out_data)
    );

endmodule

`default_nettype wire

/* tests/lane_checker.sv */
// scoreboard for the lane buffer testbench, watches the dut ports and counts every mismatch
`timescale 1ns/1ps
`default_nettype none

module lane_checker import lane_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 in_valid,
    input  wire logic [lane_w-1:0]    in_lane,
    input  wire logic [data_w-1:0]    in_data,
    input  wire logic [num_lanes-1:0] in_credit,
    input  wire logic                 out_credit,
    input  wire logic                 out_valid,
    input  wire logic [lane_w-1:0]    out_lane,
    input  wire logic [data_w-1:0]    out_data,
    input  wire logic [num_lanes-1:0] overflow,
    input  wire logic                 rr_phase,
    output int                        err_data,
    output int                        err_credit,
    output int                        err_order,
    output int                        err_ovf,
    output int                        err_reset
);

    // ring buffers, room for a full fifo plus the words in the drain pipe
    localparam int q_size = 16;

    logic [data_w-1:0] q_mem [num_lanes][q_size];
    int q_head [num_lanes];
    int q_cnt [num_lanes];

    // fifo occupancy as the rules predict it
    int fifo_cnt [num_lanes];

    // in_credit pulses and words out, per lane
    int returned [num_lanes];
    int delivered [num_lanes];

    logic [num_lanes-1:0] exp_ovf;
    int held;
    logic have_last;
    logic [lane_w-1:0] last_lane;

    int n_data = 0;
    int n_credit = 0;
    int n_order = 0;
    int n_ovf = 0;
    int n_reset = 0;

    assign err_data = n_data;
    assign err_credit = n_credit;
    assign err_order = n_order;
    assign err_ovf = n_ovf;
    assign err_reset = n_reset;

    task show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
    endtask

    // mid-cycle sampling, everything is settled here
    always @(negedge clk) begin : watch
        logic [lane_w-1:0] next_lane;
        if (!rstn) begin
            if (out_valid !== 1'b0) begin
                n_reset++;
                show_mismatch("out_valid", 0, out_valid);
            end
            if (in_credit !== '0) begin
                n_reset++;
                show_mismatch("in_credit", 0, in_credit);
            end
            if (overflow !== '0) begin
                n_reset++;
                show_mismatch("overflow", 0, overflow);
            end
            for (int l = 0; l < num_lanes; l++) begin
                q_head[l] = 0;
                q_cnt[l] = 0;
                fifo_cnt[l] = 0;
                returned[l] = 0;
                delivered[l] = 0;
            end
            exp_ovf = '0;
            held = 0;
            have_last = 1'b0;
        end else begin
            // model holds the state after the last edge
            if (overflow !== exp_ovf) begin
                n_ovf++;
                show_mismatch("overflow", exp_ovf, overflow);
            end
            // output side, a word needs a credit granted earlier
            if (out_valid) begin
                if (held == 0) begin
                    n_credit++;
                    $display("word left lane %0d at %0t with no sink credit held", out_lane, $time);
                end else begin
                    held--;
                end
                if (q_cnt[out_lane] == 0) begin
                    n_data++;
                    $display("word %0h left lane %0d at %0t but none was waiting there",
                             out_data, out_lane, $time);
                end else begin
                    if (out_data !== q_mem[out_lane][q_head[out_lane]]) begin
                        n_data++;
                        show_mismatch("out_data", q_mem[out_lane][q_head[out_lane]], out_data);
                    end
                    q_head[out_lane] = (q_head[out_lane] + 1) % q_size;
                    q_cnt[out_lane]--;
                end
                delivered[out_lane]++;
            end
            // grant of this cycle counts from the next edge on
            if (out_credit) begin
                held++;
            end
            // rotation, only while every lane stays busy
            if (!rr_phase) begin
                have_last = 1'b0;
            end else if (out_valid) begin
                next_lane = last_lane + 1'b1;
                if (have_last && out_lane !== next_lane) begin
                    n_order++;
                    show_mismatch("out_lane", next_lane, out_lane);
                end
                last_lane = out_lane;
                have_last = 1'b1;
            end
            // read of an empty lane would be a bogus credit
            for (int l = 0; l < num_lanes; l++) begin
                if (in_credit[l]) begin
                    returned[l]++;
                    if (fifo_cnt[l] == 0) begin
                        n_credit++;
                        $display("credit returned for empty lane %0d at %0t", l, $time);
                    end
                end
            end
            // full test uses the count before this edge
            if (in_valid) begin
                if (fifo_cnt[in_lane] == lane_depth) begin
                    exp_ovf[in_lane] = 1'b1;
                end else begin
                    q_mem[in_lane][(q_head[in_lane] + q_cnt[in_lane]) % q_size] = in_data;
                    q_cnt[in_lane]++;
                    fifo_cnt[in_lane]++;
                end
            end
            for (int l = 0; l < num_lanes; l++) begin
                if (in_credit[l] && fifo_cnt[l] > 0) begin
                    fifo_cnt[l]--;
                end
            end
        end
    end

    // end of run, every word out and every credit back
    task report_end;
        for (int l = 0; l < num_lanes; l++) begin
            if (returned[l] != delivered[l]) begin
                n_credit++;
                show_mismatch("in_credit pulses", delivered[l], returned[l]);
            end
            if (q_cnt[l] != 0) begin
                n_data++;
                $display("lane %0d still owes %0d words at the end of the run", l, q_cnt[l]);
            end
        end
    endtask

endmodule

`default_nettype wire

/* tests/tb_lane_buffer.sv */
// testbench top that drives the lane buffer through its test phases and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_lane_buffer import lane_pkg::*; ();

    localparam int n_random = 240;
    localparam int n_fill = num_lanes * lane_depth;
    localparam int n_ovf = lane_depth + 1;
    localparam int n_phases = 5;
    // per-word budget plus settling room for each phase
    localparam int cycle_limit = (n_random + n_fill + n_ovf) * 8 + n_phases * 200;
    localparam int sink_max = 16;
    localparam logic [lane_w-1:0] ovf_lane = 2;

    logic                 clk;
    logic                 rstn;
    logic                 in_valid;
    logic [lane_w-1:0]    in_lane;
    logic [data_w-1:0]    in_data;
    logic                 out_credit;
    logic [num_lanes-1:0] in_credit;
    logic                 out_valid;
    logic [lane_w-1:0]    out_lane;
    logic [data_w-1:0]    out_data;
    logic [num_lanes-1:0] overflow;
    logic                 rr_phase;

    // source and sink bookkeeping
    logic [15:0] lfsr;
    int src_credit [num_lanes];
    int sink_out;
    int pending;
    // 0 no grants, 1 random grants, 2 grants matched to buffered words
    int sink_mode;
    logic quiet;
    int src_errors;
    int cycles;
    int err_data;
    int err_credit;
    int err_order;
    int err_ovf;
    int err_reset;

    lane_buffer_top uut (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_lane    (in_lane),
        .in_data    (in_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_lane   (out_lane),
        .out_data   (out_data),
        .overflow   (overflow)
    );

    lane_checker chk (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_lane    (in_lane),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_lane   (out_lane),
        .out_data   (out_data),
        .overflow   (overflow),
        .rr_phase   (rr_phase),
        .err_data   (err_data),
        .err_credit (err_credit),
        .err_order  (err_order),
        .err_ovf    (err_ovf),
        .err_reset  (err_reset)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop if traffic never drains
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, traffic never finished draining", cycles);
        $display("test failed");
        $finish;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] draw(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[14:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
        end
        return val;
    endfunction

    task drive_sink;
        logic [15:0] r;
        out_credit = 1'b0;
        if (sink_mode == 1) begin
            r = draw(1);
            if (r[0] && sink_out < sink_max) out_credit = 1'b1;
        end else if (sink_mode == 2) begin
            if (sink_out < pending && sink_out < sink_max) out_credit = 1'b1;
        end
        if (out_credit) sink_out++;
    endtask

    // credits seen mid-cycle are spent from the next cycle on
    task next_cycle;
        @(negedge clk);
        for (int l = 0; l < num_lanes; l++) begin
            if (in_credit[l]) src_credit[l]++;
        end
        if (out_valid) begin
            sink_out--;
            pending--;
            if (quiet) begin
                src_errors++;
                $display("out_valid high at %0t while the sink held no credits", $time);
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        drive_sink;
    endtask

    task send_word(input logic [lane_w-1:0] lane, input logic [data_w-1:0] data);
        in_valid = 1'b1;
        in_lane = lane;
        in_data = data;
        src_credit[lane]--;
        pending++;
        next_cycle;
    endtask

    // drain until no words and no spare sink credits remain
    // extra grants are used up by topping up lane 0
    task settle;
        logic [15:0] r;
        sink_mode = 2;
        while (sink_out != 0 || pending != 0) begin
            if (sink_out > pending && src_credit[0] > 0) begin
                r = draw(data_w);
                send_word('0, r[data_w-1:0]);
            end else begin
                next_cycle;
            end
        end
    endtask

    initial begin : main
        logic [15:0] r;
        logic [lane_w-1:0] lane;
        logic [num_lanes-1:0] ovf_exp;
        int sent;
        int total;
        lfsr = 16'd70;
        rstn = 1'b0;
        in_valid = 1'b0;
        in_lane = '0;
        in_data = '0;
        out_credit = 1'b0;
        rr_phase = 1'b0;
        sink_out = 0;
        pending = 0;
        sink_mode = 0;
        quiet = 1'b0;
        src_errors = 0;
        for (int l = 0; l < num_lanes; l++) src_credit[l] = lane_depth;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        // random lanes, data and grants
        sink_mode = 1;
        sent = 0;
        while (sent < n_random) begin
            r = draw(2);
            if (r[1:0] != 2'b00) begin
                r = draw(lane_w);
                lane = r[lane_w-1:0];
                r = draw(data_w);
                if (src_credit[lane] > 0) begin
                    send_word(lane, r[data_w-1:0]);
                    sent++;
                end else begin
                    next_cycle;
                end
            end else begin
                next_cycle;
            end
        end
        settle;

        // fill all lanes with the sink silent
        sink_mode = 0;
        quiet = 1'b1;
        for (int i = 0; i < n_fill; i++) begin
            r = draw(data_w);
            send_word(lane_w'(i % num_lanes), r[data_w-1:0]);
        end
        repeat (20) next_cycle;
        // then release them in rotation
        quiet = 1'b0;
        rr_phase = 1'b1;
        settle;
        rr_phase = 1'b0;

        // fill one lane and push one word past full
        sink_mode = 0;
        quiet = 1'b1;
        for (int i = 0; i < lane_depth; i++) begin
            r = draw(data_w);
            send_word(ovf_lane, r[data_w-1:0]);
        end
        in_valid = 1'b1;
        in_lane = ovf_lane;
        in_data = 'hdead;
        next_cycle;
        ovf_exp = num_lanes'(1) << ovf_lane;
        if (overflow !== ovf_exp) begin
            src_errors++;
            $display("ERR %0t overflow expected %0h got %0h", $time, ovf_exp, overflow);
        end
        quiet = 1'b0;
        settle;
        repeat (4) next_cycle;

        // every source credit back home
        for (int l = 0; l < num_lanes; l++) begin
            if (src_credit[l] != lane_depth) begin
                src_errors++;
                $display("ERR %0t src_credit[%0d] expected %0d got %0d",
                         $time, l, lane_depth, src_credit[l]);
            end
        end
        chk.report_end;
        // end-of-run counts reach the checker ports
        #1;
        total = err_data + err_credit + err_order + err_ovf + err_reset + src_errors;
        $display("errors: data %0d credit %0d order %0d overflow %0d reset %0d source %0d",
                 err_data, err_credit, err_order, err_ovf, err_reset, src_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/lane_pkg.sv
hw/lane_ram.sv
hw/lane_fifo.sv
hw/lane_dispatch.sv
hw/lane_drain.sv
hw/lane_buffer_top.sv
tests/lane_checker.sv
tests/tb_lane_buffer.sv
